// ==== all.f ====
+incdir+include
hdl/tg_state_pkg.sv
hdl/tg_bus_pkg.sv
hdl/bmc_clock_divider.sv
hdl/bmc_input_sync.sv
hdl/access_type_fsm.sv
hdl/field_rotation_counter.sv
hdl/bout_sequencer.sv
hdl/timing_generator_top.sv
sim/tb_timing_generator.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the timing generator testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module tb_timing_generator -Mdir obj_dir -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1

cat sim.log 2>/dev/null

# the log decides, a failed build leaves no log
grep -q "Simulation completed successfully" sim.log \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }

// ==== sim/tb_timing_generator.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "tg_consts.svh"

module tb_timing_generator;

    import tg_bus_pkg::*;
    import tg_state_pkg::*;

    // strobe patterns, bit order bss_n bsen_n repen_n booten_n swapen_n
    localparam bmc_ctrl_t CTRL_RESET = 5'b11111;
    localparam bmc_ctrl_t CTRL_START = 5'b01111;  // shift start low
    localparam bmc_ctrl_t CTRL_BOOT  = 5'b10101;  // shift + bootloop enable
    localparam bmc_ctrl_t CTRL_SEEK  = 5'b10111;  // shift only
    localparam bmc_ctrl_t CTRL_REP   = 5'b10011;  // replicator pulse
    localparam bmc_ctrl_t CTRL_SWAP  = 5'b10110;  // swap pulse
    localparam int ROT_CYCLES = int'(`TG_POS_LOOP_END) - int'(`TG_POS_LOOP_START) + 1;

    logic      MCLK = 1'b0;
    logic      rst;
    logic      en_n;
    bmc_ctrl_t bmc;
    logic      clk_out;
    emu_out_t  emu;

    integer seed = 56;
    logic   mon_on = 1'b0;

    // reference model state
    int      ref_boot = int'(`TG_ABS_PAGE_INIT);
    int      rot_cnt = 0;        // data-mode rotations
    access_t last_acc = RST;
    logic [`TG_PAGE_W-1:0] last_page = `TG_ABS_PAGE_INIT;
    logic    last_bin = 1'b1;
    logic    last_bout = 1'b0;
    logic    have_bin = 1'b0;
    logic    have_page = 1'b0;
    int      bin_gap = 0;
    int      page_gap = 0;
    int      bout_pulses = 0;
    int      page_steps = 0;
    int      boot_values = 0;    // steps with a real bootloop number
    int      user_holds = 0;
    int      swap_steps = 0;
    logic    saw_wrap = 1'b0;

    timing_generator_top dut0 (
        .MCLK(MCLK), .rst(rst), .en_n(en_n), .bmc(bmc), .clk_out(clk_out), .emu(emu)
    );

    always #5 MCLK = ~MCLK;   // 100 MHz sim clock

    function automatic string value_line(input string name, input int got, input int exp);
        return $sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // expected cycle number right after a loop end
    function automatic int expected_cycle(input access_t a, input int rot, input int boot);
        if (!(a == BOOT || a == USER))
            return int'(`TG_CYCLE_NONE);            // no data out
        if (rot <= int'(`TG_PROP_DELAY))
            return int'(`TG_CYCLE_NONE);            // still propagating
        if (a == BOOT)
            return boot;
        if (rot - int'(`TG_PROP_DELAY) - 1 > int'(`TG_PAGE_CYCLE_LAST))
            return int'(`TG_PAGE_CYCLE_LAST);       // hold at end of page
        return rot - int'(`TG_PROP_DELAY) - 1;
    endfunction

    //////////////////////////////
    // stimulus helpers
    task automatic apply_ctrl(input bmc_ctrl_t p);
        int hold;
        hold = 12 + int'($unsigned($random(seed)) % 8);  // at least one 4 MHz period
        @(posedge MCLK);
        #1;
        bmc = p;
        repeat (hold) @(posedge MCLK);
    endtask

    task automatic set_enable(input logic v);
        @(posedge MCLK);
        #1;
        en_n = v;
    endtask

    task automatic wait_acc(input access_t target);
        int n;
        n = 0;
        while (emu.acc != target && n < 64)
        begin
            @(posedge MCLK);
            #2;
            n++;
        end
        if (emu.acc != target)
            stop_run($sformatf("timeout waiting for access type %s", target.name()));
    endtask

    task automatic wait_steps(input int steps);
        int target;
        int n;
        target = page_steps + steps;
        n = 0;
        while (page_steps < target && n < (steps + 2) * ROT_CYCLES)
        begin
            @(posedge MCLK);
            #2;
            n++;
        end
        if (page_steps < target)
            stop_run("timeout waiting for abs_page to advance");
    endtask

    // parked field holds bout_clken_n low
    task automatic wait_parked();
        int low_run;
        int n;
        low_run = 0;
        n = 0;
        while (low_run < 2 && n < 3 * ROT_CYCLES)
        begin
            @(posedge MCLK);
            #2;
            low_run = emu.bout_clken_n ? 0 : low_run + 1;
            n++;
        end
        if (low_run < 2)
            stop_run("field did not park after the access ended");
    endtask

    task automatic measure_clk(output int period, output int high_cycles);
        logic prev;
        int   n;
        period = 0;
        high_cycles = 0;
        n = 0;
        @(posedge MCLK);
        #2;
        prev = clk_out;
        while (!(clk_out && !prev) && n < 30)   // align to a rising edge
        begin
            prev = clk_out;
            @(posedge MCLK);
            #2;
            n++;
        end
        if (!(clk_out && !prev))
            stop_run("clk_out is not toggling");
        do
        begin
            if (clk_out)
                high_cycles++;
            period++;
            prev = clk_out;
            @(posedge MCLK);
            #2;
        end
        while (!(clk_out && !prev) && period < 30);
    endtask

    //////////////////////////////
    // compare process
    always @(negedge MCLK)
    begin : compare
        int exp_page;
        int exp_cycle;
        if (mon_on)
        begin
            page_gap++;
            bin_gap++;
            if (!emu.bout_clken_n && last_bout)
                bout_pulses++;
            if (!emu.bin_clken_n)
            begin
                assert (last_bin)
                    else stop_run("bin_clken_n stayed low for more than one cycle");
                if (have_bin)
                begin
                    assert (bin_gap == ROT_CYCLES)
                        else stop_run(value_line("bin_clken_n spacing", bin_gap, ROT_CYCLES));
                    assert (bout_pulses == 1)
                        else stop_run(value_line("bout_clken_n pulses", bout_pulses, 1));
                end
                have_bin = 1'b1;
                bin_gap = 0;
                bout_pulses = 0;
            end
            if (emu.abs_page != last_page)   // one loop end went by
            begin
                exp_page = (int'(last_page) == int'(`TG_ABS_PAGE_LAST)) ? 0
                                                                        : int'(last_page) + 1;
                assert (int'(emu.abs_page) == exp_page)
                    else stop_run(value_line("abs_page", int'(emu.abs_page), exp_page));
                if (have_page)
                begin
                    assert (page_gap == ROT_CYCLES)
                        else stop_run(value_line("abs_page spacing", page_gap, ROT_CYCLES));
                end
                ref_boot = (ref_boot == int'(`TG_BOOT_CYCLE_LAST)) ? 0 : ref_boot + 1;
                rot_cnt = (last_acc == BOOT || last_acc == USER) ? rot_cnt + 1 : 0;
                exp_cycle = expected_cycle(last_acc, rot_cnt, ref_boot);
                assert (int'(emu.cycle_num) == exp_cycle)
                    else stop_run(value_line("cycle_num", int'(emu.cycle_num), exp_cycle));
                saw_wrap = saw_wrap | (exp_page == 0);
                boot_values += (last_acc == BOOT && exp_cycle != int'(`TG_CYCLE_NONE)) ? 1 : 0;
                user_holds += (last_acc == USER && exp_cycle == int'(`TG_PAGE_CYCLE_LAST)) ? 1 : 0;
                swap_steps += (last_acc == SWAP) ? 1 : 0;
                page_steps++;
                have_page = 1'b1;
                page_gap = 0;
            end
            if (!(emu.acc inside {BOOT, USER}))
                rot_cnt = 0;                  // data mode over
            if (!(emu.acc inside {IDLE, SWAP, BOOT, USER}))
            begin
                have_bin = 1'b0;              // field stopping, spacing restarts
                have_page = 1'b0;
            end
            last_bin = emu.bin_clken_n;
            last_bout = emu.bout_clken_n;
            last_page = emu.abs_page;
            last_acc = emu.acc;
        end
    end

    //////////////////////////////
    // test sequence
    initial
    begin
        int period;
        int high_cycles;
        rst = 1'b1;
        en_n = 1'b1;
        bmc = CTRL_RESET;
        repeat (5) @(posedge MCLK);
        #1;
        rst = 1'b0;
        en_n = 1'b0;
        mon_on = 1'b1;
        @(posedge MCLK);
        #2;
        assert (int'(emu.abs_page) == int'(`TG_ABS_PAGE_INIT))
            else stop_run(value_line("abs_page", int'(emu.abs_page), int'(`TG_ABS_PAGE_INIT)));
        assert (emu.acc == RST)
            else stop_run(value_line("acc", int'(emu.acc), int'(RST)));
        assert (int'(emu.cycle_num) == int'(`TG_CYCLE_NONE))
            else stop_run(value_line("cycle_num", int'(emu.cycle_num), int'(`TG_CYCLE_NONE)));
        repeat (2)
        begin
            measure_clk(period, high_cycles);
            assert (period == 12)
                else stop_run(value_line("clk_out period", period, 12));
            assert (high_cycles == 6)
                else stop_run(value_line("clk_out high time", high_cycles, 6));
        end

        // bootloop read, runs past the abs_page wrap
        apply_ctrl(CTRL_START);
        wait_acc(STBY);
        apply_ctrl(CTRL_BOOT);
        wait_acc(BOOT);
        wait_steps(110);
        set_enable(1'b1);
        wait_acc(RST);                  // disabled reads as reset pattern
        wait_parked();
        apply_ctrl(CTRL_RESET);
        set_enable(1'b0);

        // user page read, full page plus hold
        apply_ctrl(CTRL_START);
        wait_acc(STBY);
        apply_ctrl(CTRL_SEEK);
        wait_acc(IDLE);
        apply_ctrl(CTRL_REP);
        wait_acc(USER);
        apply_ctrl(CTRL_SEEK);
        wait_steps(688);
        set_enable(1'b1);
        wait_acc(RST);
        wait_parked();
        apply_ctrl(CTRL_RESET);
        set_enable(1'b0);

        // page write
        apply_ctrl(CTRL_START);
        wait_acc(STBY);
        apply_ctrl(CTRL_SEEK);
        wait_acc(IDLE);
        apply_ctrl(CTRL_SWAP);
        wait_acc(SWAP);
        apply_ctrl(CTRL_SEEK);
        wait_steps(5);

        assert (saw_wrap)
            else stop_run("abs_page never wrapped to zero");
        assert (boot_values > 0)
            else stop_run("no bootloop cycle number was produced");
        assert (user_holds >= 3)
            else stop_run("user page count did not hold at its last value");
        assert (swap_steps >= 3)
            else stop_run("swap access saw too few rotations");
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/timing_generator_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "tg_consts.svh"

module timing_generator_top
(
    input  logic                  MCLK,
    input  logic                  rst,
    input  logic                  en_n,
    input  tg_bus_pkg::bmc_ctrl_t bmc,
    output logic                  clk_out,
    output tg_bus_pkg::emu_out_t  emu
);

    import tg_bus_pkg::*;
    import tg_state_pkg::*;

    logic                   sample_stb;
    bmc_ctrl_t              ctrl_q;
    access_t                acc;
    logic [`TG_POS_W-1:0]   pos;
    logic                   loop_end;
    logic [`TG_PAGE_W-1:0]  abs_page;
    logic [`TG_CYCLE_W-1:0] cycle_num;
    logic                   bin_clken_n;
    logic                   bout_clken_n;

    //////////////////////////////
    // input side
    bmc_clock_divider u_div (
        .MCLK(MCLK), .rst(rst), .clk_out(clk_out), .sample_stb(sample_stb)
    );

    bmc_input_sync u_sync (
        .MCLK(MCLK), .rst(rst), .en_n(en_n), .bmc(bmc),
        .sample_stb(sample_stb), .ctrl_q(ctrl_q)
    );

    //////////////////////////////
    // processing
    access_type_fsm u_fsm (.MCLK(MCLK), .rst(rst), .ctrl_q(ctrl_q), .acc(acc));

    field_rotation_counter u_rot (
        .MCLK(MCLK), .rst(rst), .acc(acc), .pos(pos),
        .loop_end(loop_end), .abs_page(abs_page)
    );

    //////////////////////////////
    // output side
    bout_sequencer u_seq (
        .MCLK(MCLK), .rst(rst), .acc(acc), .pos(pos), .loop_end(loop_end),
        .cycle_num(cycle_num), .bin_clken_n(bin_clken_n), .bout_clken_n(bout_clken_n)
    );

    assign emu = '{acc: acc, cycle_num: cycle_num, bin_clken_n: bin_clken_n,
                   bout_clken_n: bout_clken_n, abs_page: abs_page};

endmodule

`default_nettype wire

// ==== hdl/bout_sequencer.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "tg_consts.svh"

module bout_sequencer
(
    input  logic                   MCLK,
    input  logic                   rst,
    input  tg_state_pkg::access_t  acc,
    input  logic [`TG_POS_W-1:0]   pos,
    input  logic                   loop_end,
    output logic [`TG_CYCLE_W-1:0] cycle_num,
    output logic                   bin_clken_n,
    output logic                   bout_clken_n
);

    import tg_state_pkg::*;

    logic [`TG_DELAY_W-1:0] delay_cnt;  // rotations since data mode began
    logic [`TG_PCNT_W-1:0]  page_cnt;   // user page bit index
    logic [`TG_CYCLE_W-1:0] boot_cnt;   // free running, tracks abs_page
    logic [`TG_CYCLE_W-1:0] boot_next;

    assign boot_next = (boot_cnt == `TG_BOOT_CYCLE_LAST) ? '0 : boot_cnt + 1'b1;

    //////////////////////////////
    // cycle numbering
    always_ff @(posedge MCLK)
    begin
        if (rst)
        begin
            boot_cnt  <= {1'b0, `TG_ABS_PAGE_INIT};
            delay_cnt <= `TG_DELAY_NONE;
            page_cnt  <= `TG_PAGE_NONE;
            cycle_num <= `TG_CYCLE_NONE;
        end
        else if (pos == '0)
        begin
            if (acc == RST)   // field parked, drop any pending access
            begin
                delay_cnt <= `TG_DELAY_NONE;
                page_cnt  <= `TG_PAGE_NONE;
                cycle_num <= `TG_CYCLE_NONE;
            end
        end
        else if (loop_end)
        begin
            boot_cnt <= boot_next;   // always advances with the loops
            if (!data_out(acc))
            begin
                delay_cnt <= `TG_DELAY_NONE;   // idle, swap: empty line
                page_cnt  <= `TG_PAGE_NONE;
                cycle_num <= `TG_CYCLE_NONE;
            end
            else if (delay_cnt == `TG_DELAY_NONE ||
                     delay_cnt < (`TG_PROP_DELAY - 7'd1))
            begin
                delay_cnt <= delay_cnt + 1'b1;  // none wraps to 0
                page_cnt  <= `TG_PAGE_NONE;
                cycle_num <= `TG_CYCLE_NONE;
            end
            else if (!is_user(acc))
            begin
                page_cnt  <= `TG_PAGE_NONE;
                cycle_num <= boot_next;        // bootloop bit number
            end
            else if (page_cnt == `TG_PAGE_NONE ||
                     page_cnt < `TG_PAGE_CYCLE_LAST)
            begin
                page_cnt  <= page_cnt + 1'b1;  // none wraps to 0
                cycle_num <= {3'b000, page_cnt + 1'b1};
            end
            // else hold at 583 until the access ends
        end
    end

    //////////////////////////////
    // data clock enables
    always_ff @(posedge MCLK)
    begin
        if (rst)
        begin
            bin_clken_n  <= 1'b1;
            bout_clken_n <= 1'b0;   // parked field counts as launch point
        end
        else
        begin
            bin_clken_n  <= !(pos == `TG_POS_FIRST_BIN || loop_end);
            bout_clken_n <= !(pos == '0 || pos == `TG_POS_BOUT);  // -Y
        end
    end

    a_clken_excl : assert property (@(posedge MCLK) disable iff (rst)
        !(!bin_clken_n && !bout_clken_n));

endmodule

`default_nettype wire

// ==== hdl/field_rotation_counter.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "tg_consts.svh"

module field_rotation_counter
(
    input  logic                  MCLK,
    input  logic                  rst,
    input  tg_state_pkg::access_t acc,
    output logic [`TG_POS_W-1:0]  pos,       // field position in MCLK
    output logic                  loop_end,  // +Y reached
    output logic [`TG_PAGE_W-1:0] abs_page   // page under the detector
);

    import tg_state_pkg::*;

    //////////////////////////////
    // rotation position
    //        +Y 568
    // -X 208        +X 448
    //        -Y 328
    always_ff @(posedge MCLK)
    begin
        if (rst)
        begin
            pos <= '0;
        end
        else if (pos == '0)
        begin
            if (field_active(acc))
                pos <= pos + 1'b1;   // field starts turning
        end
        else if (pos == `TG_POS_STOP)
        begin
            if (field_active(acc))
                pos <= pos + 1'b1;
            else
                pos <= '0;           // park at -X
        end
        else if (pos == `TG_POS_LOOP_END)
        begin
            pos <= `TG_POS_LOOP_START;   // 480 clocks per rotation
        end
        else
        begin
            pos <= pos + 1'b1;
        end
    end

    assign loop_end = (pos == `TG_POS_LOOP_END);

    //////////////////////////////
    // absolute page, mod 2053
    always_ff @(posedge MCLK)
    begin
        if (rst)
            abs_page <= `TG_ABS_PAGE_INIT;
        else if (loop_end)
        begin
            if (abs_page == `TG_ABS_PAGE_LAST)
                abs_page <= '0;
            else
                abs_page <= abs_page + 1'b1;
        end
    end

    a_pos_range : assert property (@(posedge MCLK) disable iff (rst)
        pos <= `TG_POS_LOOP_END);

endmodule

`default_nettype wire

// ==== hdl/access_type_fsm.sv ====
`default_nettype none
`timescale 1ns/1ps

module access_type_fsm
(
    input  logic                   MCLK,
    input  logic                   rst,
    input  tg_bus_pkg::bmc_ctrl_t  ctrl_q,
    output tg_state_pkg::access_t  acc
);

    import tg_state_pkg::*;

    logic [4:0] pat;      // bss, booten, bsen, repen, swapen
    access_t    acc_nxt;

    assign pat = {ctrl_q.bss_n, ctrl_q.booten_n, ctrl_q.bsen_n,
                  ctrl_q.repen_n, ctrl_q.swapen_n};

    //////////////////////////////
    // next state decode
    always_comb
    begin
        acc_nxt = acc;  // hold on anything else
        case (pat)
            5'b10111, 5'b11111: // shift stopped, bootloop or page side
            begin
                if (acc != STBY)
                    acc_nxt = RST;
            end
            5'b00111, 5'b01111: // shift start pulse
            begin
                if (acc == RST)
                    acc_nxt = STBY;
            end
            5'b10011: // bootloop read
            begin
                if (acc == STBY || acc == RST || acc == BOOT)
                    acc_nxt = BOOT;
            end
            5'b11011: // page seek, field running without data
            begin
                if (acc == STBY || acc == RST)
                    acc_nxt = IDLE;
            end
            5'b11001: // replicator pulse
            begin
                if (acc == IDLE)
                    acc_nxt = USER;
            end
            5'b11010: // swap pulse, page write
            begin
                if (acc == IDLE)
                    acc_nxt = SWAP;
            end
            default:
            begin
                acc_nxt = acc;
            end
        endcase
    end

    always_ff @(posedge MCLK)
    begin
        if (rst)
            acc <= RST;
        else
            acc <= acc_nxt;
    end

    a_acc_legal : assert property (@(posedge MCLK) disable iff (rst)
        acc inside {RST, STBY, BOOT, USER, IDLE, SWAP});

endmodule

`default_nettype wire

// ==== hdl/bmc_input_sync.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "tg_consts.svh"

module bmc_input_sync
(
    input  logic                  MCLK,
    input  logic                  rst,
    input  logic                  en_n,
    input  tg_bus_pkg::bmc_ctrl_t bmc,
    input  logic                  sample_stb,
    output tg_bus_pkg::bmc_ctrl_t ctrl_q
);

    import tg_bus_pkg::*;

    bmc_ctrl_t gated;             // idle pattern while disabled
    bmc_ctrl_t sync1;
    bmc_ctrl_t sync2;
    bmc_ctrl_t sync3;

    assign gated = en_n ? bmc_ctrl_t'(`TG_CTRL_IDLE) : bmc;

    //////////////////////////////
    // metastability chain
    always_ff @(posedge MCLK)
    begin
        if (rst)
        begin
            sync1 <= `TG_CTRL_IDLE;
            sync2 <= `TG_CTRL_IDLE;
            sync3 <= `TG_CTRL_IDLE;
        end
        else
        begin
            sync1 <= gated;
            sync2 <= sync1;
            sync3 <= sync2;
        end
    end

    // capture only on the 12 MHz grid, 4..7 clocks total latency
    always_ff @(posedge MCLK)
    begin
        if (rst)
            ctrl_q <= `TG_CTRL_IDLE;
        else if (sample_stb)
            ctrl_q <= sync3;
    end

endmodule

`default_nettype wire

// ==== hdl/bmc_clock_divider.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "tg_consts.svh"

module bmc_clock_divider
(
    input  logic MCLK,
    input  logic rst,
    output logic clk_out,     // 4 MHz to the controller
    output logic sample_stb   // 12 MHz capture strobe
);

    logic [3:0] phase;  // 0..11

    //////////////////////////////
    // phase counter
    always_ff @(posedge MCLK)
    begin
        if (rst)
            phase <= 4'd0;
        else if (phase == `TG_PHASE_LAST)
            phase <= 4'd0;
        else
            phase <= phase + 4'd1;
    end

    // 6 high, 6 low, starts high
    always_ff @(posedge MCLK)
    begin
        if (rst)
            clk_out <= 1'b1;
        else if (phase == `TG_PHASE_CLK_RISE)
            clk_out <= 1'b1;
        else if (phase == `TG_PHASE_CLK_FALL)
            clk_out <= 1'b0;   // controller launches on this falling edge
    end

    assign sample_stb = (phase == `TG_SAMPLE_PHASE_A) ||
                        (phase == `TG_SAMPLE_PHASE_B) ||
                        (phase == `TG_SAMPLE_PHASE_C);

    a_phase_range : assert property (@(posedge MCLK) disable iff (rst)
        phase <= `TG_PHASE_LAST);

endmodule

`default_nettype wire

// ==== hdl/tg_bus_pkg.sv ====
`default_nettype none

`include "tg_consts.svh"

package tg_bus_pkg;

    // bubble memory controller strobes, all active low
    typedef struct packed {
        logic bss_n;     // shift start
        logic bsen_n;    // shift enable
        logic repen_n;   // replicator enable
        logic booten_n;  // bootloop enable
        logic swapen_n;  // swap gate enable
    } bmc_ctrl_t;

    // emulator side
    typedef struct packed {
        tg_state_pkg::access_t       acc;
        logic [`TG_CYCLE_W-1:0]      cycle_num;
        logic                        bin_clken_n;
        logic                        bout_clken_n;
        logic [`TG_PAGE_W-1:0]       abs_page;
    } emu_out_t;

endpackage

`default_nettype wire

// ==== hdl/tg_state_pkg.sv ====
`default_nettype none

package tg_state_pkg;

    // bit 2 field on, bit 1 data out, bit 0 user page
    typedef enum logic [2:0] {
        RST  = 3'b000,
        STBY = 3'b001,
        IDLE = 3'b100,
        SWAP = 3'b101,
        BOOT = 3'b110,
        USER = 3'b111
    } access_t;

    // magnetic field rotating
    function automatic logic field_active(input access_t a);
        return a[2];
    endfunction

    // detector data goes out
    function automatic logic data_out(input access_t a);
        return a[1];
    endfunction

    function automatic logic is_user(input access_t a);
        return a[0];
    endfunction

endpackage

`default_nettype wire

// ==== include/tg_consts.svh ====
`ifndef TG_CONSTS_SVH
`define TG_CONSTS_SVH

// divider phases, 12 MCLK per 4 MHz period
`define TG_PHASE_LAST       4'd11
`define TG_PHASE_CLK_RISE   4'd5
`define TG_PHASE_CLK_FALL   4'd11
`define TG_SAMPLE_PHASE_A   4'd3   // 12 MHz capture points
`define TG_SAMPLE_PHASE_B   4'd7
`define TG_SAMPLE_PHASE_C   4'd11

// field rotation positions in MCLK, +Y at 568 and -X at 208
`define TG_POS_FIRST_BIN    10'd88
`define TG_POS_LOOP_START   10'd89
`define TG_POS_STOP         10'd208
`define TG_POS_BOUT         10'd326  // -Y minus two clocks
`define TG_POS_LOOP_END     10'd568

// loop lengths
`define TG_ABS_PAGE_LAST    12'd2052  // 2053 positions per minor loop
`define TG_ABS_PAGE_INIT    12'd1951
`define TG_BOOT_CYCLE_LAST  13'd4105  // two bootloops interleaved
`define TG_PAGE_CYCLE_LAST  10'd583
`define TG_PROP_DELAY       7'd98     // rotations from replicator to detector

// idle / reset values
`define TG_CYCLE_NONE       13'd8191
`define TG_DELAY_NONE       7'd127
`define TG_PAGE_NONE        10'd1023
`define TG_CTRL_IDLE        5'b11101  // all strobes high, booten_n low

// widths
`define TG_POS_W            10
`define TG_PAGE_W           12
`define TG_CYCLE_W          13
`define TG_DELAY_W          7
`define TG_PCNT_W           10

`endif
